//--- logic/data_memory.sv
`timescale 1ns/1ps

module data_memory (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               mem_req_valid,
    input  mem_pkg::mem_req_t  mem_req,
    output logic               mem_ack,
    output mem_pkg::mem_rsp_t  mem_rsp
);

    // byte array, no reset
    logic [7:0] mem [mem_pkg::mem_bytes];

    // latency countdown
    logic busy;
    logic [$clog2(mem_pkg::mem_latency)-1:0] lat_cnt;
    logic fire;

    // address decode, upper bits ignored
    logic [mem_pkg::mem_addr_w-1:0] byte_addr;
    logic [mem_pkg::mem_addr_w-3:0] word_idx;

    assign byte_addr = mem_req.addr[mem_pkg::mem_addr_w-1:0];
    assign word_idx = byte_addr[mem_pkg::mem_addr_w-1:2];

    // access happens on the edge that raises ack
    assign fire = busy && (lat_cnt == '0);

    // handshake and counter
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
            lat_cnt <= '0;
            mem_ack <= 1'b0;
        end else begin
            if (!busy && !mem_ack && mem_req_valid) begin
                // first sight of req
                busy <= 1'b1;
                lat_cnt <= $bits(lat_cnt)'(mem_pkg::mem_latency - 1);
            end else if (fire) begin
                busy <= 1'b0;
                mem_ack <= 1'b1;
            end else if (busy) begin
                lat_cnt <= lat_cnt - 1'b1;
            end else if (mem_ack && !mem_req_valid) begin
                // requester let go
                mem_ack <= 1'b0;
            end
        end
    end

    // storage access, little-endian word lanes
    always_ff @(posedge clk) begin
        if (fire) begin
            if (mem_req.write) begin
                if (mem_req.byte_op) begin
                    mem[byte_addr] <= mem_req.wdata[7:0];
                end else begin
                    mem[{word_idx, 2'd0}] <= mem_req.wdata[7:0];
                    mem[{word_idx, 2'd1}] <= mem_req.wdata[15:8];
                    mem[{word_idx, 2'd2}] <= mem_req.wdata[23:16];
                    mem[{word_idx, 2'd3}] <= mem_req.wdata[31:24];
                end
                mem_rsp.rdata <= '0;
            end else if (mem_req.byte_op) begin
                mem_rsp.rdata <= {24'b0, mem[byte_addr]};
            end else begin
                mem_rsp.rdata <= {mem[{word_idx, 2'd3}], mem[{word_idx, 2'd2}],
                                  mem[{word_idx, 2'd1}], mem[{word_idx, 2'd0}]};
            end
        end
    end

endmodule

//--- logic/ls_issue.sv
`timescale 1ns/1ps

module ls_issue (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                head_valid,
    input  ls_pkg::lsq_entry_t  head,
    output logic                pop,
    output logic                mem_req_valid,
    output mem_pkg::mem_req_t   mem_req,
    input  logic                mem_ack,
    input  mem_pkg::mem_rsp_t   mem_rsp,
    output logic                done_valid,
    output ls_pkg::done_t       done
);

    // idle, request out, waiting for ack to drop
    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_drain
    } state_e;

    state_e state;

    logic start;
    logic finish;
    mem_pkg::mem_req_t req_next;

    // new request only from idle, which implies ack is already low
    assign start = (state == st_idle) && head_valid;
    assign finish = (state == st_req) && mem_ack;

    // request fields from the head opcode
    always_comb begin
        req_next.addr = head.addr;
        case (head.alloc.op)
            ls_pkg::op_lw: begin
                req_next.write = 1'b0;
                req_next.byte_op = 1'b0;
                req_next.wdata = '0;
            end
            ls_pkg::op_lb: begin
                req_next.write = 1'b0;
                req_next.byte_op = 1'b1;
                req_next.wdata = '0;
            end
            ls_pkg::op_sw: begin
                req_next.write = 1'b1;
                req_next.byte_op = 1'b0;
                req_next.wdata = head.store_data;
            end
            default: begin
                // byte store, upper lanes dropped
                req_next.write = 1'b1;
                req_next.byte_op = 1'b1;
                req_next.wdata = {24'b0, head.store_data[7:0]};
            end
        endcase
    end

    // handshake sequencing
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            mem_req_valid <= 1'b0;
            pop <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            // single-cycle pulses
            pop <= 1'b0;
            done_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        mem_req_valid <= 1'b1;
                        state <= st_req;
                    end
                end
                st_req: begin
                    // ack seen: release req, free head, report
                    if (mem_ack) begin
                        mem_req_valid <= 1'b0;
                        pop <= 1'b1;
                        done_valid <= 1'b1;
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    // four-phase return to zero
                    if (!mem_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request held stable from launch until ack
    always_ff @(posedge clk) begin
        if (start) begin
            mem_req <= req_next;
        end
    end

    // completion payload, head is still the issuing entry here
    always_ff @(posedge clk) begin
        if (finish) begin
            done.is_load <= ~mem_req.write;
            done.phys_rd <= head.alloc.phys_rd;
            done.rob_tag <= head.alloc.rob_tag;
            if (mem_req.write) begin
                done.load_data <= '0;
            end else if (mem_req.byte_op) begin
                // zero-extend the returned byte
                done.load_data <= {{(ls_pkg::data_w - 8){1'b0}}, mem_rsp.rdata[7:0]};
            end else begin
                done.load_data <= mem_rsp.rdata;
            end
        end
    end

endmodule

//--- logic/ls_pkg.sv
package ls_pkg;

    // queue geometry
    localparam int lsq_depth = 16;
    localparam int lsq_idx_w = 4;

    // tag, register and datapath widths
    localparam int tag_w = 6;
    localparam int preg_w = 6;
    localparam int data_w = 32;

    // high bit marks a store, low bit a byte access
    typedef enum logic [1:0] {
        op_lw = 2'd0,
        op_lb = 2'd1,
        op_sw = 2'd2,
        op_sb = 2'd3
    } ls_op_e;

    // fields known at decode
    typedef struct packed {
        ls_op_e op;
        logic [preg_w-1:0] phys_rd;
        logic [tag_w-1:0] rob_tag;
    } alloc_t;

    // address port payload, found by tag
    typedef struct packed {
        logic [tag_w-1:0] rob_tag;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] store_data;
    } fill_t;

    // one queue slot
    typedef struct packed {
        alloc_t alloc;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] store_data;
    } lsq_entry_t;

    // completion toward rob and wakeup
    typedef struct packed {
        logic is_load;
        logic [preg_w-1:0] phys_rd;
        logic [tag_w-1:0] rob_tag;
        logic [data_w-1:0] load_data;
    } done_t;

endpackage

//--- logic/ls_queue.sv
`timescale 1ns/1ps

module ls_queue (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                alloc_valid,
    input  ls_pkg::alloc_t      alloc,
    output logic                alloc_ready,
    input  logic                fill_valid,
    input  ls_pkg::fill_t       fill,
    output logic                head_valid,
    output ls_pkg::lsq_entry_t  head,
    input  logic                pop
);

    // entry storage, payload only
    ls_pkg::lsq_entry_t entries [ls_pkg::lsq_depth];

    // per-slot state
    logic [ls_pkg::lsq_depth-1:0] entry_valid;
    logic [ls_pkg::lsq_depth-1:0] entry_ready;

    // circular pointers
    logic [ls_pkg::lsq_idx_w-1:0] head_ptr;
    logic [ls_pkg::lsq_idx_w-1:0] tail_ptr;

    // occupancy, one bit wider to hold the full count
    logic [ls_pkg::lsq_idx_w:0] count;

    logic alloc_fire;
    logic [ls_pkg::lsq_depth-1:0] fill_hit;

    // full only when every slot is taken
    assign alloc_ready = (count != (ls_pkg::lsq_idx_w + 1)'(ls_pkg::lsq_depth));
    assign alloc_fire = alloc_valid && alloc_ready;

    // oldest entry goes out once its address has arrived
    assign head_valid = entry_valid[head_ptr] && entry_ready[head_ptr];
    assign head = entries[head_ptr];

    // tag compare against every live slot
    // a slot allocated this cycle is not yet valid, so it cannot match
    always_comb begin
        for (int i = 0; i < ls_pkg::lsq_depth; i++) begin
            fill_hit[i] = fill_valid && entry_valid[i] &&
                          (entries[i].alloc.rob_tag == fill.rob_tag);
        end
    end

    // slot contents
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entries[tail_ptr].alloc <= alloc;
        end
        for (int i = 0; i < ls_pkg::lsq_depth; i++) begin
            if (fill_hit[i]) begin
                entries[i].addr <= fill.addr;
                entries[i].store_data <= fill.store_data;
            end
        end
    end

    // flags, pointers and count
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid <= '0;
            entry_ready <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end else begin
            // filled slots become ready
            entry_ready <= entry_ready | fill_hit;

            // new slot waits for its address
            if (alloc_fire) begin
                entry_valid[tail_ptr] <= 1'b1;
                entry_ready[tail_ptr] <= 1'b0;
                tail_ptr <= tail_ptr + 1'b1;
            end

            // retire the head, last so it wins over a late fill
            if (pop) begin
                entry_valid[head_ptr] <= 1'b0;
                entry_ready[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end

            // alloc and pop together leave count alone
            case ({alloc_fire, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/ls_unit.sv
`timescale 1ns/1ps

module ls_unit (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            alloc_valid,
    input  ls_pkg::alloc_t  alloc,
    output logic            alloc_ready,
    input  logic            fill_valid,
    input  ls_pkg::fill_t   fill,
    output logic            done_valid,
    output ls_pkg::done_t   done
);

    // queue to sequencer
    logic head_valid;
    ls_pkg::lsq_entry_t head;
    logic pop;

    // sequencer to memory
    logic mem_req_valid;
    mem_pkg::mem_req_t mem_req;
    logic mem_ack;
    mem_pkg::mem_rsp_t mem_rsp;

    // in-order entry buffer
    ls_queue u_queue (
        .clk         (clk),
        .reset_n     (reset_n),
        .alloc_valid (alloc_valid),
        .alloc       (alloc),
        .alloc_ready (alloc_ready),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop)
    );

    // one operation at a time against memory
    ls_issue u_issue (
        .clk           (clk),
        .reset_n       (reset_n),
        .head_valid    (head_valid),
        .head          (head),
        .pop           (pop),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rsp       (mem_rsp),
        .done_valid    (done_valid),
        .done          (done)
    );

    // fixed-latency backing store
    data_memory u_mem (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rsp       (mem_rsp)
    );

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    // backing store size
    localparam int mem_bytes = 4096;
    localparam int mem_addr_w = 12;

    // cycles from req seen to ack raised
    localparam int mem_latency = 10;

    // request held stable for the whole handshake
    typedef struct packed {
        logic write;
        logic byte_op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // response, valid while ack is high
    // byte reads come back in the low lane
    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
        --top-module ls_unit_tb -Mdir obj_dir -o ls_unit_sim; then
    echo "verilator build failed"
    exit 1
fi

# raised error limit lets the testbench reach its own report
if ! ./obj_dir/ls_unit_sim +verilator+error+limit+1000 > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0

//--- src.f
logic/ls_pkg.sv
logic/mem_pkg.sv
logic/ls_queue.sv
logic/ls_issue.sv
logic/data_memory.sv
logic/ls_unit.sv
verif/ls_unit_assertions.sv
verif/ls_unit_tb.sv

//--- verif/ls_unit_assertions.sv
`timescale 1ns/1ps

module ls_unit_assertions (
    input logic               clk,
    input logic               reset_n,
    input logic               mem_req_valid,
    input mem_pkg::mem_req_t  mem_req,
    input logic               mem_ack,
    input logic               pop,
    input logic               head_valid
);

    // failure tally, read back at the end of the run
    int failures = 0;

    // request payload frozen until the memory answers
    assert property (@(posedge clk) disable iff (!reset_n)
        mem_req_valid && !mem_ack |=> $stable(mem_req))
    else begin
        $error("mem_req changed while waiting for mem_ack");
        failures++;
    end

    // ack only rises into a live request
    assert property (@(posedge clk) disable iff (!reset_n)
        $rose(mem_ack) |-> mem_req_valid)
    else begin
        $error("mem_ack rose without mem_req_valid");
        failures++;
    end

    // sequencer frees only a ready head
    assert property (@(posedge clk) disable iff (!reset_n)
        pop |-> head_valid)
    else begin
        $error("pop without a valid head entry");
        failures++;
    end

endmodule

bind ls_unit ls_unit_assertions u_assertions (
    .clk           (clk),
    .reset_n       (reset_n),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .pop           (pop),
    .head_valid    (head_valid)
);

//--- verif/ls_unit_stim.txt
# name op tag phys_rd addr(hex) store_data(hex) shuffle exp_load_data(hex)
# op 0 lw, 1 lb, 2 sw, 3 sb; shuffle 1 sends the group's fills in lcg order
sw_lw 2 1 0 00000100 deadbeef 0 00000000
sw_lw 0 2 5 00000100 00000000 0 deadbeef
sb_lane 2 3 0 00000200 11223344 0 00000000
sb_lane 3 4 0 00000202 ffffffa5 0 00000000
sb_lane 0 5 9 00000200 00000000 0 11a53344
lb_zext 2 6 0 00000300 80c0e0f0 0 00000000
lb_zext 1 7 12 00000301 00000000 0 000000e0
lb_zext 1 8 13 00000303 00000000 0 00000080
shuffled 2 10 0 f0000500 01020304 1 00000000
shuffled 2 11 0 00000504 a0b0c0d0 1 00000000
shuffled 3 12 0 00000506 0000007e 1 00000000
shuffled 0 13 21 00000500 00000000 1 01020304
shuffled 0 14 22 00000504 00000000 1 a07ec0d0
full_q 2 40 0 00000600 10000001 1 00000000
full_q 2 41 0 00000604 20000002 1 00000000
full_q 2 42 0 00000608 30000003 1 00000000
full_q 2 43 0 0000060c 40000004 1 00000000
full_q 2 44 0 00000610 5e4d3c2b 1 00000000
full_q 2 45 0 00000614 60000006 1 00000000
full_q 2 46 0 00000618 7a6b5c4d 1 00000000
full_q 2 47 0 0000061c 80000008 1 00000000
full_q 0 48 30 00000600 00000000 1 10000001
full_q 0 49 31 00000604 00000000 1 20000002
full_q 1 50 32 00000608 00000000 1 00000003
full_q 0 51 33 0000060c 00000000 1 40000004
full_q 1 52 34 00000613 00000000 1 0000005e
full_q 0 53 35 00000614 00000000 1 60000006
full_q 1 54 36 0000061a 00000000 1 0000006b
full_q 0 55 37 0000061c 00000000 1 80000008

//--- verif/ls_unit_tb.sv
`timescale 1ns/1ps

module ls_unit_tb;

    localparam int max_ops = 64;
    localparam int wait_limit = 400;

    // one row of the stim file
    typedef struct packed {
        logic [127:0] name;
        logic [1:0] op;
        logic [ls_pkg::tag_w-1:0] tag;
        logic [ls_pkg::preg_w-1:0] phys_rd;
        logic [31:0] addr;
        logic [31:0] store_data;
        logic shuffle;
        logic [31:0] exp_data;
    } stim_t;

    logic clk;
    logic reset_n;
    logic alloc_valid;
    ls_pkg::alloc_t alloc;
    logic alloc_ready;
    logic fill_valid;
    ls_pkg::fill_t fill;
    logic done_valid;
    ls_pkg::done_t done;

    stim_t ops [max_ops];
    int n_ops;
    ls_pkg::done_t done_q [$];
    int unsigned lcg_state;
    int errors;
    int checks;
    int tests;
    bit timed_out;

    ls_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // completions taken at the falling edge, clear of the update
    always @(negedge clk) begin
        if (reset_n && done_valid) begin
            done_q.push_back(done);
        end
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input logic [127:0] test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %0s %0s expected %h actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    task automatic read_stim();
        int fd;
        int n;
        string line;
        logic [127:0] name;
        logic [1:0] op;
        logic [ls_pkg::tag_w-1:0] tag;
        logic [ls_pkg::preg_w-1:0] rd;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic sh;
        logic [31:0] exp;
        fd = $fopen("verif/ls_unit_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/ls_unit_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_ops < max_ops) begin
            line = "";
            n = $fgets(line, fd);
            // skip blank and comment lines
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %h %h %d %h", name, op, tag, rd,
                            addr, sdata, sh, exp);
                if (n != 8) begin
                    $display("unreadable stim line: %s", line);
                    errors++;
                end else begin
                    ops[n_ops] = {name, op, tag, rd, addr, sdata, sh, exp};
                    n_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one allocation attempt, held for a single edge
    task automatic drive_alloc(input stim_t s);
        alloc_valid = 1'b1;
        alloc.op = ls_pkg::ls_op_e'(s.op);
        alloc.phys_rd = s.phys_rd;
        alloc.rob_tag = s.tag;
        @(posedge clk);
        #1;
        alloc_valid = 1'b0;
    endtask

    task automatic run_group(input int first, input int last);
        int order [$];
        int j;
        int tmp;
        int cycles;
        int errs_before;
        stim_t s;
        ls_pkg::done_t d;
        errs_before = errors;
        // allocate in file order
        for (int i = first; i <= last; i++) begin
            cycles = 0;
            while (!alloc_ready && cycles < wait_limit) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!alloc_ready) begin
                $display("timeout: alloc_ready stuck low in %0s", ops[i].name);
                errors++;
                timed_out = 1'b1;
                return;
            end
            drive_alloc(ops[i]);
            order.push_back(i);
        end
        // full queue, one extra entry must bounce
        if (last - first + 1 == ls_pkg::lsq_depth) begin
            check_value(ops[first].name, "alloc_ready full", 32'd0, 32'(alloc_ready));
            s = ops[first];
            s.tag = '1;
            drive_alloc(s);
            check_value(ops[first].name, "alloc_ready extra", 32'd0, 32'(alloc_ready));
        end
        // fisher-yates over the fill order
        if (ops[first].shuffle) begin
            for (int i = order.size() - 1; i > 0; i--) begin
                lcg_state = lcg_next(lcg_state);
                j = int'((lcg_state >> 16) % (i + 1));
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
        // address port, one fill per cycle
        foreach (order[k]) begin
            fill_valid = 1'b1;
            fill.rob_tag = ops[order[k]].tag;
            fill.addr = ops[order[k]].addr;
            fill.store_data = ops[order[k]].store_data;
            @(posedge clk);
            #1;
        end
        fill_valid = 1'b0;
        // completions must follow allocation order
        for (int i = first; i <= last; i++) begin
            cycles = 0;
            while (done_q.size() == 0 && cycles < wait_limit) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (done_q.size() == 0) begin
                $display("timeout: no completion for %0s tag %0d", ops[i].name, ops[i].tag);
                errors++;
                timed_out = 1'b1;
                return;
            end
            d = done_q.pop_front();
            check_value(ops[i].name, "rob_tag", 32'(ops[i].tag), 32'(d.rob_tag));
            check_value(ops[i].name, "is_load", 32'(!ops[i].op[1]), 32'(d.is_load));
            check_value(ops[i].name, "phys_rd", 32'(ops[i].phys_rd), 32'(d.phys_rd));
            check_value(ops[i].name, "load_data", ops[i].exp_data, d.load_data);
        end
        // full group drained so there is room again
        if (last - first + 1 == ls_pkg::lsq_depth) begin
            check_value(ops[first].name, "alloc_ready drained", 32'd1, 32'(alloc_ready));
        end
        tests++;
        $display("test %0s: %0d ops, %0d errors", ops[first].name, last - first + 1,
                 errors - errs_before);
    endtask

    initial begin
        int first;
        reset_n = 1'b0;
        alloc_valid = 1'b0;
        alloc = '0;
        fill_valid = 1'b0;
        fill = '0;
        n_ops = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        timed_out = 1'b0;
        lcg_state = 72407;
        read_stim();
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("reset", "alloc_ready", 32'd1, 32'(alloc_ready));
        // consecutive rows with one name form a group
        first = 0;
        for (int i = 1; i <= n_ops && !timed_out; i++) begin
            if (i == n_ops || ops[i].name != ops[first].name) begin
                run_group(first, i - 1);
                first = i;
            end
        end
        // quiet period, nothing more may complete
        repeat (40) @(posedge clk);
        #1;
        assert (done_q.size() == 0) else begin
            $display("unexpected completion after the last test");
            errors++;
        end
        assert (u_dut.u_assertions.failures == 0) else begin
            $display("bound handshake or queue assertions failed %0d times",
                     u_dut.u_assertions.failures);
            errors++;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
